//--- common/mat_pkg.sv
`default_nettype none

package mat_pkg;

    // matrix edge length
    localparam int DIM = 4;

    // row or column index
    localparam int IDX_W = $clog2(DIM);

    // element address is {row, col}
    localparam int ADDR_W = 2 * IDX_W;

endpackage

`default_nettype wire

//--- common/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // exe_ctrl FSM
    // idle, k loop of one row, wait for the shadow copy, wait for the last write-out
    typedef enum logic [1:0] {
        IDLE,
        KLOOP,
        WAIT_UPD,
        DRAIN
    } exe_state_t;

    // target of a host write
    typedef enum logic {
        SEL_A,
        SEL_B
    } op_sel_t;

endpackage

`default_nettype wire

//--- hdl/agu.sv
`default_nettype none

module agu
    import mat_pkg::*;
#(
    parameter int W = IDX_W
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         en,
    output logic [W-1:0] data,
    output logic         last
);

    localparam logic [W-1:0] FINAL = W'(DIM - 1);

    // high between start and the final count
    logic armed;

    assign last = armed && (data == FINAL);

    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
            data  <= '0;
        end else if (start) begin
            // start wins over a running count
            armed <= 1'b1;
            data  <= '0;
        end else if (en && armed) begin
            if (last) begin
                // final value seen, stop and park at zero
                armed <= 1'b0;
                data  <= '0;
            end else begin
                data <= data + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- ctrl/exe_ctrl.sv
`default_nettype none

module exe_ctrl
    import mat_pkg::*, ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  logic             update,
    input  logic             out_fin,
    output logic             busy,
    output logic             done,
    output logic             s_init,
    output logic             k_init,
    output logic             k_fin,
    output logic             mac_en,
    output logic             mac_clr,
    output logic [IDX_W-1:0] row_i,
    output logic [IDX_W-1:0] col_k
);

    exe_state_t       state;
    logic             start_ok;
    logic             k_last;
    logic             row_last;
    // write-outs finished in this run
    logic [IDX_W-1:0] fin_cnt;

    // start only counts when idle
    assign start_ok = start && (state == IDLE);
    assign busy     = (state != IDLE);
    // accumulators cleared together with each row's k_init
    assign mac_clr  = k_init;

    // row counter, steps once per finished k loop
    agu #(.W(IDX_W)) u_row (
        .clk   (clk),
        .rst   (rst),
        .start (s_init),
        .en    (k_fin),
        .data  (row_i),
        .last  (row_last)
    );

    // k counter, free running once loaded
    agu #(.W(IDX_W)) u_k (
        .clk   (clk),
        .rst   (rst),
        .start (k_init),
        .en    (1'b1),
        .data  (col_k),
        .last  (k_last)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            s_init  <= 1'b0;
            k_init  <= 1'b0;
            k_fin   <= 1'b0;
            mac_en  <= 1'b0;
            done    <= 1'b0;
            fin_cnt <= '0;
        end else begin
            s_init <= start_ok;
            // first row right after s_init, later rows after the shadow copy
            k_init <= s_init || ((state == WAIT_UPD) && update);
            k_fin  <= k_last;
            done   <= 1'b0;

            // mac_en covers k = 0..3
            if (k_init) begin
                mac_en <= 1'b1;
            end else if (k_last) begin
                mac_en <= 1'b0;
            end

            // out_fin can arrive in any busy state
            if (start_ok) begin
                fin_cnt <= '0;
            end else if (out_fin) begin
                fin_cnt <= fin_cnt + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (start_ok) begin
                        state <= KLOOP;
                    end
                end
                KLOOP: begin
                    if (k_last) begin
                        state <= row_last ? DRAIN : WAIT_UPD;
                    end
                end
                WAIT_UPD: begin
                    // accumulators are free once update copied them
                    if (update) begin
                        state <= KLOOP;
                    end
                end
                DRAIN: begin
                    // fourth write-out ends the run
                    if (out_fin && (fin_cnt == IDX_W'(DIM - 1))) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ctrl/out_ctrl.sv
`default_nettype none

module out_ctrl
    import mat_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              s_init,
    input  logic              k_init,
    input  logic              k_fin,
    output logic              out_busy,
    output logic              out_period,
    output logic              out_fin,
    output logic [ADDR_W-1:0] out_addr,
    output logic              update
);

    logic [IDX_W-1:0]  i;
    logic [IDX_W-1:0]  j;
    logic              last_j;
    logic              last_j_next;
    logic              j_period;
    logic              k_fin_retention;
    logic              row_live;
    logic              k_end;
    logic              start_o;
    logic              out_period_pre;
    logic              update_after_start;
    logic [ADDR_W-1:0] out_addr_pre;

    // only a k_fin that closes an opened row counts
    assign k_end = k_fin && row_live;

    // direct start when idle, else handover right after the last column
    assign start_o = (k_end && !out_busy)
                   || (last_j_next && (k_end || k_fin_retention));

    // output row index, loaded per run, steps at each row's last column
    agu #(.W(IDX_W)) u_i (
        .clk   (clk),
        .rst   (rst),
        .start (s_init),
        .en    (last_j),
        .data  (i),
        .last  ()
    );

    // column counter, four cycles after start_o
    agu #(.W(IDX_W)) u_j (
        .clk   (clk),
        .rst   (rst),
        .start (start_o),
        .en    (1'b1),
        .data  (j),
        .last  (last_j)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            row_live           <= 1'b0;
            j_period           <= 1'b0;
            out_busy           <= 1'b0;
            k_fin_retention    <= 1'b0;
            last_j_next        <= 1'b0;
            out_period_pre     <= 1'b0;
            out_period         <= 1'b0;
            out_fin            <= 1'b0;
            update_after_start <= 1'b0;
            update             <= 1'b0;
        end else begin
            // open from k_init to k_fin of a row
            if (k_init) begin
                row_live <= 1'b1;
            end else if (k_fin) begin
                row_live <= 1'b0;
            end

            // column period, start_o+1 .. last_j
            if (start_o) begin
                j_period <= 1'b1;
            end else if (last_j) begin
                j_period <= 1'b0;
            end

            // write-out running, includes the handover cycle
            if (start_o) begin
                out_busy <= 1'b1;
            end else if (last_j_next) begin
                out_busy <= 1'b0;
            end

            // park a k_fin that hits a running write-out
            if (last_j_next) begin
                k_fin_retention <= 1'b0;
            end else if (k_end && out_busy) begin
                k_fin_retention <= 1'b1;
            end

            last_j_next <= last_j;

            // out_period is j_period two cycles late
            out_period_pre <= j_period;
            out_period     <= out_period_pre;
            // falling edge of out_period
            out_fin        <= out_period && !out_period_pre;

            // shadow copy lands one cycle before out_period
            update_after_start <= start_o;
            update             <= update_after_start;
        end
    end

    // address pipeline, same delay as out_period
    always_ff @(posedge clk) begin
        out_addr_pre <= {i, j};
        out_addr     <= out_addr_pre;
    end

endmodule

`default_nettype wire

//--- hdl/mac_row.sv
`default_nettype none

module mac_row
    import mat_pkg::*;
#(
    parameter int DATA_W = 8,
    parameter int ACC_W  = 18
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        mac_en,
    input  logic                        mac_clr,
    input  logic                        update,
    input  logic [DATA_W-1:0]           a_elem,
    input  logic [DIM-1:0][DATA_W-1:0]  b_row,
    input  logic [IDX_W-1:0]            col,
    output logic [ACC_W-1:0]            c_elem
);

    logic [2*DATA_W-1:0]         prod [DIM];
    logic [DIM-1:0][ACC_W-1:0]   acc;
    // copy handed to the write-out while the next row accumulates
    logic [DIM-1:0][ACC_W-1:0]   shadow;

    // one product per output column
    always_comb begin
        for (int j = 0; j < DIM; j++) begin
            prod[j] = a_elem * b_row[j];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || mac_clr) begin
            acc <= '0;
        end else if (mac_en) begin
            for (int j = 0; j < DIM; j++) begin
                acc[j] <= acc[j] + ACC_W'(prod[j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            shadow <= acc;
        end
    end

    assign c_elem = shadow[col];

endmodule

`default_nettype wire

//--- hdl/src_buf.sv
`default_nettype none

module src_buf
    import mat_pkg::*, ctrl_pkg::*;
#(
    parameter int DATA_W = 8
) (
    input  logic                       clk,
    input  logic                       wr_en,
    input  op_sel_t                    wr_sel,
    input  logic [ADDR_W-1:0]          wr_addr,
    input  logic [DATA_W-1:0]          wr_data,
    input  logic [IDX_W-1:0]           row_i,
    input  logic [IDX_W-1:0]           col_k,
    output logic [DATA_W-1:0]          a_elem,
    output logic [DIM-1:0][DATA_W-1:0] b_row
);

    // both stored row-major, index {row, col}
    logic [DATA_W-1:0] a_mem [DIM*DIM];
    logic [DATA_W-1:0] b_mem [DIM*DIM];

    always_ff @(posedge clk) begin
        if (wr_en && (wr_sel == SEL_A)) begin
            a_mem[wr_addr] <= wr_data;
        end
        if (wr_en && (wr_sel == SEL_B)) begin
            b_mem[wr_addr] <= wr_data;
        end
    end

    // A[i][k]
    assign a_elem = a_mem[{row_i, col_k}];

    // whole row k of B
    always_comb begin
        for (int j = 0; j < DIM; j++) begin
            b_row[j] = b_mem[{col_k, IDX_W'(j)}];
        end
    end

endmodule

`default_nettype wire

//--- hdl/dst_buf.sv
`default_nettype none

module dst_buf
    import mat_pkg::*;
#(
    parameter int ACC_W = 18
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              out_period,
    input  logic [ADDR_W-1:0] out_addr,
    input  logic [ACC_W-1:0]  c_elem,
    output logic [IDX_W-1:0]  col,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [ACC_W-1:0]  rd_data
);

    logic              period_q;
    logic [ADDR_W-1:0] addr_q;
    logic [ACC_W-1:0]  mem [DIM*DIM];

    always_ff @(posedge clk) begin
        if (rst) begin
            period_q <= 1'b0;
        end else begin
            period_q <= out_period;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= out_addr;
        // c_elem follows col from the staged address
        if (period_q) begin
            mem[addr_q] <= c_elem;
        end
    end

    assign col     = addr_q[IDX_W-1:0];
    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

//--- hdl/matmul_top.sv
`default_nettype none

module matmul_top
    import mat_pkg::*, ctrl_pkg::*;
#(
    parameter int DATA_W = 8,
    // wide enough for four full-scale products
    parameter int ACC_W  = 2 * DATA_W + 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  op_sel_t           wr_sel,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              start,
    output logic              busy,
    output logic              done,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [ACC_W-1:0]  rd_data
);

    logic                       s_init;
    logic                       k_init;
    logic                       k_fin;
    logic                       mac_en;
    logic                       mac_clr;
    logic                       update;
    logic                       out_fin;
    logic                       out_period;
    logic [ADDR_W-1:0]          out_addr;
    logic [IDX_W-1:0]           row_i;
    logic [IDX_W-1:0]           col_k;
    logic [IDX_W-1:0]           col;
    logic [DATA_W-1:0]          a_elem;
    logic [DIM-1:0][DATA_W-1:0] b_row;
    logic [ACC_W-1:0]           c_elem;

    exe_ctrl u_exe_ctrl (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .update  (update),
        .out_fin (out_fin),
        .busy    (busy),
        .done    (done),
        .s_init  (s_init),
        .k_init  (k_init),
        .k_fin   (k_fin),
        .mac_en  (mac_en),
        .mac_clr (mac_clr),
        .row_i   (row_i),
        .col_k   (col_k)
    );

    // out_busy only steers out_ctrl itself
    out_ctrl u_out_ctrl (
        .clk        (clk),
        .rst        (rst),
        .s_init     (s_init),
        .k_init     (k_init),
        .k_fin      (k_fin),
        .out_busy   (),
        .out_period (out_period),
        .out_fin    (out_fin),
        .out_addr   (out_addr),
        .update     (update)
    );

    src_buf #(.DATA_W(DATA_W)) u_src_buf (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .row_i   (row_i),
        .col_k   (col_k),
        .a_elem  (a_elem),
        .b_row   (b_row)
    );

    mac_row #(.DATA_W(DATA_W), .ACC_W(ACC_W)) u_mac_row (
        .clk     (clk),
        .rst     (rst),
        .mac_en  (mac_en),
        .mac_clr (mac_clr),
        .update  (update),
        .a_elem  (a_elem),
        .b_row   (b_row),
        .col     (col),
        .c_elem  (c_elem)
    );

    dst_buf #(.ACC_W(ACC_W)) u_dst_buf (
        .clk        (clk),
        .rst        (rst),
        .out_period (out_period),
        .out_addr   (out_addr),
        .c_elem     (c_elem),
        .col        (col),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

//--- sim/matmul_assertions.sv
`default_nettype none

module matmul_assertions
    import ctrl_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       out_period,
    input logic       update,
    input logic       k_init,
    input logic [1:0] exe_state
);

    timeunit 1ns;
    timeprecision 1ps;

    // one write-out window is four columns long
    a_period_len: assert property (
        @(posedge clk) disable iff (rst)
        $fell(out_period) |-> ($past(out_period, 1) && $past(out_period, 2)
                              && $past(out_period, 3) && $past(out_period, 4)
                              && !$past(out_period, 5))
    ) else $error("out_period did not last exactly four cycles");

    // shadow copy is taken the cycle before the window opens
    a_update_lead: assert property (
        @(posedge clk) disable iff (rst)
        update |=> $rose(out_period)
    ) else $error("out_period did not open right after update");

    // accumulators must not be cleared before the copy
    a_no_kinit_wait: assert property (
        @(posedge clk) disable iff (rst)
        !(k_init && (exe_state == 2'(WAIT_UPD)))
    ) else $error("k_init seen while waiting for update");

endmodule

// output side, no FSM here so the state is tied to idle
bind out_ctrl matmul_assertions u_out_assert (
    .clk        (clk),
    .rst        (rst),
    .out_period (out_period),
    .update     (update),
    .k_init     (k_init),
    .exe_state  (2'b00)
);

// execution side, no output window here
bind exe_ctrl matmul_assertions u_exe_assert (
    .clk        (clk),
    .rst        (rst),
    .out_period (1'b0),
    .update     (1'b0),
    .k_init     (k_init),
    .exe_state  (state)
);

`default_nettype wire

//--- sim/tb_matmul.sv
`default_nettype none

module tb_matmul
    import mat_pkg::*, ctrl_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_W    = 8;
    localparam int ACC_W     = 2 * DATA_W + 2;
    localparam int N_ELEM    = DIM * DIM;
    localparam int TIMEOUT   = 300;
    localparam int N_RANDOM  = 20;
    localparam logic [31:0] LFSR_SEED = 32'hc92021e2;

    logic              clk;
    logic              rst;
    logic              wr_en;
    op_sel_t           wr_sel;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              start;
    logic              busy;
    logic              done;
    logic [ADDR_W-1:0] rd_addr;
    logic [ACC_W-1:0]  rd_data;

    // operands and expected product, row-major
    logic [DATA_W-1:0] a_mat [N_ELEM];
    logic [DATA_W-1:0] b_mat [N_ELEM];
    logic [ACC_W-1:0]  c_exp [N_ELEM];
    // two pairs of A, B and C
    logic [ACC_W-1:0]  stim_mem [2 * 3 * N_ELEM];
    logic [31:0]       lfsr;
    int                done_cnt = 0;
    int                runs;

    matmul_top #(
        .DATA_W (DATA_W),
        .ACC_W  (ACC_W)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    always #5ns clk = ~clk;

    // every done pulse, sampled away from the edge
    always @(negedge clk) begin
        if (!rst && done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    // right shift, taps folded in when a one drops out
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic write_elem(input op_sel_t sel, input int addr,
                              input logic [DATA_W-1:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_sel  <= sel;
        wr_addr <= ADDR_W'(addr);
        wr_data <= data;
    endtask

    // B always, A only when asked
    task automatic load_operands(input bit with_a);
        if (with_a) begin
            for (int e = 0; e < N_ELEM; e++) begin
                write_elem(SEL_A, e, a_mat[e]);
            end
        end
        for (int e = 0; e < N_ELEM; e++) begin
            write_elem(SEL_B, e, b_mat[e]);
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic load_stim_pair(input int p);
        int base;
        base = p * 3 * N_ELEM;
        for (int e = 0; e < N_ELEM; e++) begin
            a_mat[e] = stim_mem[base + e][DATA_W-1:0];
            b_mat[e] = stim_mem[base + N_ELEM + e][DATA_W-1:0];
            c_exp[e] = stim_mem[base + 2 * N_ELEM + e];
        end
    endtask

    task automatic random_operands(input bit new_a);
        logic [31:0] v;
        for (int e = 0; e < N_ELEM; e++) begin
            if (new_a) begin
                draw_bits(DATA_W, v);
                a_mat[e] = v[DATA_W-1:0];
            end
            draw_bits(DATA_W, v);
            b_mat[e] = v[DATA_W-1:0];
        end
    endtask

    // C[i][j] = sum over k of A[i][k] * B[k][j]
    task automatic compute_expected();
        int sum;
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                sum = 0;
                for (int k = 0; k < DIM; k++) begin
                    sum += a_mat[i * DIM + k] * b_mat[k * DIM + j];
                end
                c_exp[i * DIM + j] = ACC_W'(sum);
            end
        end
    endtask

    // extra_start_at < 0 means no second start during the run
    task automatic run_matrix(input int extra_start_at);
        int n;
        bit seen;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("busy after start", busy, 1);
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(posedge clk);
            start <= (n == extra_start_at);
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
                // busy drops with the done pulse
                check_value("busy with done", busy, 0);
            end else begin
                check_value("busy during run", busy, 1);
            end
            n++;
        end
        if (!seen) begin
            fail_now("timeout: done did not arrive within the cycle limit");
        end
        @(posedge clk);
        start <= 1'b0;
        runs++;
    endtask

    task automatic read_check(input string label);
        for (int a = 0; a < N_ELEM; a++) begin
            @(posedge clk);
            rd_addr <= ADDR_W'(a);
            @(negedge clk);
            check_value($sformatf("%s C[%0d][%0d]", label, a / DIM, a % DIM),
                        rd_data, c_exp[a]);
        end
        // one done per run so far
        check_value("done pulse count", done_cnt, runs);
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        wr_en   = 1'b0;
        wr_sel  = SEL_A;
        wr_addr = '0;
        wr_data = '0;
        start   = 1'b0;
        rd_addr = '0;
        lfsr    = LFSR_SEED;
        runs    = 0;
        $readmemh("sim/matmul_stim.txt", stim_mem);

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("busy after reset", busy, 0);
        check_value("done after reset", done, 0);

        // fixed pairs from the data file
        for (int p = 0; p < 2; p++) begin
            load_stim_pair(p);
            load_operands(1'b1);
            run_matrix(-1);
            read_check($sformatf("stim pair %0d", p));
        end

        // second start while busy, then a quiet window for a stray done
        load_stim_pair(0);
        load_operands(1'b1);
        run_matrix(5);
        repeat (60) @(negedge clk);
        read_check("start while busy");

        for (int r = 0; r < N_RANDOM; r++) begin
            random_operands(1'b1);
            compute_expected();
            load_operands(1'b1);
            run_matrix(-1);
            read_check($sformatf("random pair %0d", r));
        end

        // A stays from the last pair
        random_operands(1'b0);
        compute_expected();
        load_operands(1'b0);
        run_matrix(-1);
        read_check("new B only");

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/matmul_stim.txt
// per pair: 4 rows of A, 4 rows of B, then 4 rows of expected C = A*B
// one matrix row per line, columns 0..3, hex
01 02 03 04
05 06 07 08
09 0A 0B 0C
0D 0E 0F 10
02 00 00 00
00 01 00 00
00 00 01 01
01 00 00 01
06 02 03 07
12 06 07 0F
1E 0A 0B 17
2A 0E 0F 1F
FF FF FF FF
01 00 00 00
00 00 00 80
10 20 30 40
FF 01 00 02
FF 00 03 00
FF 04 00 00
FF 00 00 05
3F804 4FB 2FD 6F9
FF 1 0 2
7F80 0 0 280
9F60 D0 60 160

//--- all.f
common/mat_pkg.sv
common/ctrl_pkg.sv
hdl/agu.sv
ctrl/exe_ctrl.sv
ctrl/out_ctrl.sv
hdl/mac_row.sv
hdl/src_buf.sv
hdl/dst_buf.sv
hdl/matmul_top.sv
sim/matmul_assertions.sv
sim/tb_matmul.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the matmul testbench with Verilator.
# Exit status is nonzero when the build fails or the simulation fails.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_matmul -f all.f --Mdir obj_dir -o tb_matmul
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_matmul
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0
